// ==== tb.f ====
uart_pkg.sv
uart_bus_decode.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_bus_result.sv
uart_top.sv
uart_checker.sv
tb_uart.sv

// ==== run.sh ====
#!/usr/bin/env bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_uart -o tb_uart_sim \
  && ./obj_dir/tb_uart_sim 2>&1 | tee sim.log \
  && grep -q "^Testbench passed$" sim.log \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

// ==== tb_uart.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart;

  // Thirteen frames of 160 cycles make up most of the run. This leaves a wide margin.
  localparam int TIMEOUT_CYCLES = 20_000;

  logic       clk;
  logic       reset;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [1:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic       wb_ack;
  logic       serial_rx;
  logic       serial_tx;
  int         cycle_count;

  uart_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_dat_o    (wb_dat_r),
    .wb_ack_o    (wb_ack),
    .serial_rx_i (serial_rx),
    .serial_tx_o (serial_tx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $fatal(1);
  end

  task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // Status word as the register map defines it.
  function automatic logic [7:0] expected_status(input logic rx_valid, input logic frame_err,
                                                 input logic tx_full, input logic overrun);
    logic [7:0] word;
    word = 8'd0;
    word[uart_pkg::STAT_RX_VALID] = rx_valid;
    word[uart_pkg::STAT_RX_FRAME_ERR] = frame_err;
    word[uart_pkg::STAT_TX_FULL] = tx_full;
    word[uart_pkg::STAT_RX_OVERRUN] = overrun;
    return word;
  endfunction

  // Holds the request until ack is seen, then ends the bus cycle.
  task automatic wait_ack();
    do begin
      @(posedge clk);
    end while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] addr, input logic [7:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b1;
    wb_adr <= addr;
    wb_dat_w <= data;
    wait_ack();
  endtask

  task automatic wb_read(input logic [1:0] addr, output logic [7:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b0;
    wb_adr <= addr;
    wait_ack();
    data = wb_dat_r;
  endtask

  task automatic check_status(input string what, input logic [7:0] exp);
    logic [7:0] rd;
    wb_read(uart_pkg::ADDR_STATUS, rd);
    check_value(what, rd, exp);
  endtask

  task automatic check_data(input string what, input logic [7:0] exp);
    logic [7:0] rd;
    wb_read(uart_pkg::ADDR_DATA, rd);
    check_value(what, rd, exp);
  endtask

  // Start bit, data LSB first, then the given stop value.
  task automatic send_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      serial_rx <= bits[i];
      repeat (uart_pkg::BIT_CYCLES) @(posedge clk);
    end
    serial_rx <= 1'b1;
  endtask

  task automatic expect_frame(input logic [7:0] data);
    logic [7:0] got;
    do begin
      @(posedge clk);
    end while (serial_tx);
    // First low sample seen; step on to the middle of the start bit.
    repeat (uart_pkg::BIT_CYCLES / 2 - 1) @(posedge clk);
    check_value("start bit", {7'd0, serial_tx}, 8'd0);
    for (int i = 0; i < 8; i++) begin
      repeat (uart_pkg::BIT_CYCLES) @(posedge clk);
      got[i] = serial_tx;
    end
    repeat (uart_pkg::BIT_CYCLES) @(posedge clk);
    check_value("transmitted byte", got, data);
    check_value("stop bit", {7'd0, serial_tx}, 8'd1);
  endtask

  task automatic test_reset_state();
    check_value("serial_tx after reset", {7'd0, serial_tx}, 8'd1);
    check_value("ack after reset", {7'd0, wb_ack}, 8'd0);
    check_status("status after reset", expected_status(1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic test_single_tx();
    logic [7:0] data;
    data = random_byte();
    wb_write(uart_pkg::ADDR_DATA, data);
    expect_frame(data);
  endtask

  // One byte moves to the shifter, the rest fill the FIFO.
  task automatic test_tx_queue();
    logic [7:0] sent [uart_pkg::FIFO_DEPTH + 1];
    for (int i = 0; i < uart_pkg::FIFO_DEPTH + 1; i++) begin
      sent[i] = random_byte();
    end
    // The first frame starts while the other bytes are still being written.
    fork
      begin
        for (int i = 0; i < uart_pkg::FIFO_DEPTH + 1; i++) begin
          wb_write(uart_pkg::ADDR_DATA, sent[i]);
        end
        check_status("status with tx queue full", expected_status(1'b0, 1'b0, 1'b1, 1'b0));
      end
      begin
        for (int i = 0; i < uart_pkg::FIFO_DEPTH + 1; i++) begin
          expect_frame(sent[i]);
        end
      end
    join
    check_status("status after tx queue drained", expected_status(1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic test_rx_single();
    logic [7:0] data;
    data = random_byte();
    send_frame(data, 1'b1);
    check_status("status after one frame", expected_status(1'b1, 1'b0, 1'b0, 1'b0));
    check_data("received byte", data);
    check_status("status after data read", expected_status(1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic test_rx_frame_err();
    logic [7:0] data;
    data = random_byte();
    send_frame(data, 1'b0);
    check_status("status after bad stop", expected_status(1'b1, 1'b1, 1'b0, 1'b0));
    check_data("byte with framing error", data);
  endtask

  task automatic test_rx_overrun();
    logic [7:0] sent [uart_pkg::FIFO_DEPTH + 1];
    for (int i = 0; i < uart_pkg::FIFO_DEPTH + 1; i++) begin
      sent[i] = random_byte();
      send_frame(sent[i], 1'b1);
    end
    check_status("status after overrun", expected_status(1'b1, 1'b0, 1'b0, 1'b1));
    check_status("status after overrun clear", expected_status(1'b1, 1'b0, 1'b0, 1'b0));
    for (int i = 0; i < uart_pkg::FIFO_DEPTH; i++) begin
      check_data("queued receive byte", sent[i]);
    end
    check_status("status after rx drained", expected_status(1'b0, 1'b0, 1'b0, 1'b0));
  endtask

  initial begin
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = 8'd0;
    serial_rx = 1'b1;
    void'($urandom(32'hcf8b_cc53));
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_single_tx();
    test_tx_queue();
    test_rx_single();
    test_rx_frame_err();
    test_rx_overrun();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_checker (
  input wire logic clk,
  input wire logic reset,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_ack_i,
  input wire logic serial_tx_i
);

  // Ack answers a request that was on the bus one cycle earlier.
  ack_after_request: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("ack raised without cyc and stb in the previous cycle");

  ack_single_cycle: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack_i |=> !wb_ack_i
  ) else $error("ack held high for two cycles in a row");

  // The line idles high straight out of reset.
  tx_idle_after_reset: assert property (
    @(posedge clk)
    reset |=> serial_tx_i
  ) else $error("serial_tx_o not high in the cycle after reset");

endmodule

bind uart_top uart_checker i_checker (
  .clk         (clk),
  .reset       (reset),
  .wb_cyc_i    (wb_cyc_i),
  .wb_stb_i    (wb_stb_i),
  .wb_ack_i    (wb_ack_o),
  .serial_tx_i (serial_tx_o)
);

`default_nettype wire

// ==== uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_top (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       wb_cyc_i,
  input  wire logic       wb_stb_i,
  input  wire logic       wb_we_i,
  input  wire logic [1:0] wb_adr_i,
  input  wire logic [7:0] wb_dat_i,
  output logic [7:0]      wb_dat_o,
  output logic            wb_ack_o,
  input  wire logic       serial_rx_i,
  output logic            serial_tx_o
);

  logic                reg_wr_data;
  logic                reg_rd_data;
  logic                reg_rd_status;
  logic                req;

  logic                tx_pop;
  logic [7:0]          tx_head;
  logic                tx_empty;
  logic                tx_full;

  logic                rx_push;
  uart_pkg::rx_entry_t rx_push_entry;
  logic                rx_pop;
  uart_pkg::rx_entry_t rx_head;
  logic                rx_empty;
  logic                rx_full;
  logic                overrun;

  uart_bus_decode i_decode (
    .clk             (clk),
    .reset           (reset),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .reg_wr_data_o   (reg_wr_data),
    .reg_rd_data_o   (reg_rd_data),
    .reg_rd_status_o (reg_rd_status),
    .req_o           (req)
  );

  uart_fifo #(.payload_t(logic [7:0])) i_tx_fifo (
    .clk         (clk),
    .reset       (reset),
    .push_i      (reg_wr_data),
    .push_data_i (wb_dat_i),
    .pop_i       (tx_pop),
    .head_o      (tx_head),
    .empty_o     (tx_empty),
    .full_o      (tx_full)
  );

  uart_tx i_tx (
    .clk          (clk),
    .reset        (reset),
    .fifo_empty_i (tx_empty),
    .fifo_head_i  (tx_head),
    .fifo_pop_o   (tx_pop),
    .serial_tx_o  (serial_tx_o)
  );

  uart_rx i_rx (
    .clk           (clk),
    .reset         (reset),
    .serial_rx_i   (serial_rx_i),
    .fifo_full_i   (rx_full),
    .overrun_clr_i (reg_rd_status),
    .push_o        (rx_push),
    .push_entry_o  (rx_push_entry),
    .overrun_o     (overrun)
  );

  uart_fifo #(.payload_t(uart_pkg::rx_entry_t)) i_rx_fifo (
    .clk         (clk),
    .reset       (reset),
    .push_i      (rx_push),
    .push_data_i (rx_push_entry),
    .pop_i       (rx_pop),
    .head_o      (rx_head),
    .empty_o     (rx_empty),
    .full_o      (rx_full)
  );

  uart_bus_result i_result (
    .clk             (clk),
    .reset           (reset),
    .req_i           (req),
    .reg_rd_data_i   (reg_rd_data),
    .reg_rd_status_i (reg_rd_status),
    .rx_empty_i      (rx_empty),
    .rx_head_i       (rx_head),
    .tx_full_i       (tx_full),
    .overrun_i       (overrun),
    .rx_pop_o        (rx_pop),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o)
  );

endmodule

`default_nettype wire

// ==== uart_bus_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_bus_result (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                req_i,
  input  wire logic                reg_rd_data_i,
  input  wire logic                reg_rd_status_i,
  input  wire logic                rx_empty_i,
  input  wire uart_pkg::rx_entry_t rx_head_i,
  input  wire logic                tx_full_i,
  input  wire logic                overrun_i,
  output logic                     rx_pop_o,
  output logic [7:0]               wb_dat_o,
  output logic                     wb_ack_o
);

  logic [7:0] status_word;
  logic [7:0] rd_data;

  always_comb begin
    status_word = '0;
    status_word[uart_pkg::STAT_RX_VALID] = !rx_empty_i;
    // Head entry is stale when the FIFO is empty.
    status_word[uart_pkg::STAT_RX_FRAME_ERR] = rx_head_i.frame_err && !rx_empty_i;
    status_word[uart_pkg::STAT_TX_FULL] = tx_full_i;
    status_word[uart_pkg::STAT_RX_OVERRUN] = overrun_i;
  end

  always_comb begin
    rd_data = '0;
    if (reg_rd_data_i && !rx_empty_i) begin
      rd_data = rx_head_i.data;
    end else if (reg_rd_status_i) begin
      rd_data = status_word;
    end
  end

  // Head is captured on the same edge that pops it. The FIFO drops an empty pop.
  assign rx_pop_o = reg_rd_data_i;

  always_ff @(posedge clk) begin
    wb_dat_o <= rd_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req_i;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         serial_rx_i,
  input  wire logic         fifo_full_i,
  input  wire logic         overrun_clr_i,
  output logic              push_o,
  output uart_pkg::rx_entry_t push_entry_o,
  output logic              overrun_o
);

  localparam int CNT_W = $clog2(uart_pkg::BIT_CYCLES);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(uart_pkg::BIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(uart_pkg::BIT_CYCLES / 2 - 1);

  typedef enum logic [1:0] {
    RX_HUNT,
    RX_START_HALF,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             sync_q1;
  logic             sync_q2;
  logic [CNT_W-1:0] cycle_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       data_q;
  logic             frame_err_q;
  logic             done_q;

  // Two-flop synchronizer. Idles high so reset does not look like a start bit.
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
    end else begin
      sync_q1 <= serial_rx_i;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RX_HUNT;
      done_q <= 1'b0;
      cycle_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done_q <= 1'b0;
      case (state)
        RX_HUNT: begin
          cycle_cnt <= '0;
          if (!sync_q2) begin
            state <= RX_START_HALF;
          end
        end
        RX_START_HALF: begin
          if (cycle_cnt != HALF_LAST) begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end else begin
            // A glitch, not a start bit, if the line is back high at mid-bit.
            cycle_cnt <= '0;
            bit_cnt <= '0;
            state <= sync_q2 ? RX_HUNT : RX_DATA;
          end
        end
        RX_DATA: begin
          if (cycle_cnt != BIT_LAST) begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end else begin
            cycle_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (cycle_cnt != BIT_LAST) begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end else begin
            done_q <= 1'b1;
            state <= RX_HUNT;
          end
        end
        default: state <= RX_HUNT;
      endcase
    end
  end

  // Payload shifts in LSB first; stop sample becomes the framing flag.
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cycle_cnt == BIT_LAST) begin
      data_q <= {sync_q2, data_q[7:1]};
    end
    if (state == RX_STOP && cycle_cnt == BIT_LAST) begin
      frame_err_q <= !sync_q2;
    end
  end

  assign push_o = done_q;
  assign push_entry_o.data = data_q;
  assign push_entry_o.frame_err = frame_err_q;

  // Sticky until a status read. A new loss in the same cycle wins.
  always_ff @(posedge clk) begin
    if (reset) begin
      overrun_o <= 1'b0;
    end else if (done_q && fifo_full_i) begin
      overrun_o <= 1'b1;
    end else if (overrun_clr_i) begin
      overrun_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       fifo_empty_i,
  input  wire logic [7:0] fifo_head_i,
  output logic            fifo_pop_o,
  output logic            serial_tx_o
);

  localparam int CNT_W = $clog2(uart_pkg::BIT_CYCLES);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(uart_pkg::BIT_CYCLES - 1);

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] cycle_cnt;
  logic [3:0]       bit_cnt;
  logic [8:0]       shift_q;

  // Take the next byte as soon as the shifter is idle.
  assign fifo_pop_o = (state == TX_IDLE) && !fifo_empty_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= TX_IDLE;
      serial_tx_o <= 1'b1;
      cycle_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          serial_tx_o <= 1'b1;
          if (fifo_pop_o) begin
            // Start bit goes out right away; stop bit rides in the top of the shifter.
            serial_tx_o <= 1'b0;
            cycle_cnt <= '0;
            bit_cnt <= '0;
            state <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (cycle_cnt != BIT_LAST) begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end else if (bit_cnt == 4'd9) begin
            serial_tx_o <= 1'b1;
            state <= TX_IDLE;
          end else begin
            cycle_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            serial_tx_o <= shift_q[0];
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Data bits LSB first, then the stop bit.
  always_ff @(posedge clk) begin
    if (fifo_pop_o) begin
      shift_q <= {1'b1, fifo_head_i};
    end else if (state == TX_SEND && cycle_cnt == BIT_LAST) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

`default_nettype wire

// ==== uart_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     push_i,
  input  wire payload_t push_data_i,
  input  wire logic     pop_i,
  output payload_t      head_o,
  output logic          empty_o,
  output logic          full_o
);

  localparam int PTR_W = $clog2(uart_pkg::FIFO_DEPTH);
  localparam int CNT_W = $clog2(uart_pkg::FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(uart_pkg::FIFO_DEPTH - 1);

  payload_t         mem [uart_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Overflowing pushes and underflowing pops are dropped here.
  assign do_push = push_i && !full_o;
  assign do_pop = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_o = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o = (count == CNT_W'(uart_pkg::FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== uart_bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_bus_decode (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       wb_cyc_i,
  input  wire logic       wb_stb_i,
  input  wire logic       wb_we_i,
  input  wire logic [1:0] wb_adr_i,
  output logic            reg_wr_data_o,
  output logic            reg_rd_data_o,
  output logic            reg_rd_status_o,
  output logic            req_o
);

  logic pending_q;
  logic accept;
  logic sel_data;
  logic sel_status;

  // A request is taken once per bus cycle. The pending bit masks the ack cycle,
  // when the master still holds stb high.
  assign accept = wb_cyc_i && wb_stb_i && !pending_q;

  assign sel_data = (wb_adr_i == uart_pkg::ADDR_DATA);
  assign sel_status = (wb_adr_i == uart_pkg::ADDR_STATUS);

  always_ff @(posedge clk) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= accept;
    end
  end

  assign reg_wr_data_o = accept && wb_we_i && sel_data;
  assign reg_rd_data_o = accept && !wb_we_i && sel_data;
  assign reg_rd_status_o = accept && !wb_we_i && sel_status;

  // Every accepted access gets an ack, including ignored ones.
  assign req_o = accept;

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // Line timing. The clock is the 100 ns testbench clock.
  localparam int CLOCK_RATE = 10_000_000;
  localparam int BAUD = 625_000;
  localparam int BIT_CYCLES = CLOCK_RATE / BAUD;

  // Entries held in each FIFO.
  localparam int FIFO_DEPTH = 4;

  // Register map on the 2-bit Wishbone address bus.
  localparam logic [1:0] ADDR_DATA = 2'd0;
  localparam logic [1:0] ADDR_STATUS = 2'd1;

  // Bit positions in the status word.
  localparam int STAT_RX_VALID = 0;
  localparam int STAT_RX_FRAME_ERR = 1;
  localparam int STAT_TX_FULL = 2;
  localparam int STAT_RX_OVERRUN = 3;

  // One received byte with its framing error flag.
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;
  } rx_entry_t;

endpackage

`default_nettype wire
